// ==== Bender.yml ====
package:
  name: exec_cluster

sources:
  - design/exec_cfg_pkg.sv
  - design/exec_types_pkg.sv
  - design/issue_dispatch.sv
  - design/alu_lane.sv
  - design/result_collect.sv
  - design/exec_cluster.sv
  - target: test
    files:
      - tb/tb_clock_gen.sv
      - tb/exec_cluster_sva.sv
      - tb/tb_exec_cluster.sv

// ==== design/alu_lane.sv ====
// two-cycle lane, low half then high half; a new op may enter every cycle, there is no stall
`default_nettype none

module alu_lane (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      in_valid,
  input  exec_types_pkg::exec_op_t  in_op,
  output logic                      out_valid,
  output exec_types_pkg::lane_res_t out_res
);
  import exec_cfg_pkg::*;
  import exec_types_pkg::*;

  function automatic logic cond_true(cond_e cond, flags_t f);
    case (cond)
      cond_eq: return f.z;
      cond_ne: return !f.z;
      cond_cs: return f.c;
      cond_cc: return !f.c;
      cond_mi: return f.n;
      cond_pl: return !f.n;
      cond_vs: return f.v;
      cond_vc: return !f.v;
      cond_hi: return f.c && !f.z;
      cond_ls: return !f.c || f.z;
      cond_ge: return f.n == f.v;
      cond_lt: return f.n != f.v;
      cond_gt: return !f.z && (f.n == f.v);
      cond_le: return f.z || (f.n != f.v);
      cond_al: return 1'b1;
      default: return 1'b0; // nv
    endcase
  endfunction

  logic [half_w-1:0] a_lo, b_lo, b_lo_eff, lo_val;
  logic [half_w:0]   lo_sum;
  logic              is_sub, cond_ok;

  // stage 1: condition and low half
  always_comb begin
    a_lo     = in_op.a[half_w-1:0];
    b_lo     = in_op.b[half_w-1:0];
    is_sub   = (in_op.opcode == op_sub);
    cond_ok  = cond_true(in_op.cond, in_op.flags_in);
    b_lo_eff = is_sub ? ~b_lo : b_lo;
    lo_sum   = {1'b0, a_lo} + {1'b0, b_lo_eff} + {{half_w{1'b0}}, is_sub};
    case (in_op.opcode)
      op_add, op_sub: lo_val = lo_sum[half_w-1:0];
      op_and:         lo_val = a_lo & b_lo;
      op_or:          lo_val = a_lo | b_lo;
      op_xor:         lo_val = a_lo ^ b_lo;
      op_sxtb:        lo_val = {{(half_w-8){a_lo[7]}}, a_lo[7:0]};
      op_sxth:        lo_val = {{(half_w-16){a_lo[15]}}, a_lo[15:0]};
      default:        lo_val = a_lo; // sxtw keeps the word
    endcase
    if (!cond_ok) begin
      case (in_op.else_sel)
        else_a:    lo_val = a_lo;
        else_one:  lo_val = half_w'(1);
        else_zero: lo_val = '0;
        default:   lo_val = '1;
      endcase
    end
  end

  logic              s1_valid;
  logic              s1_cond_ok;
  logic              s1_carry;
  logic [tag_w-1:0]  s1_tag;
  op_e               s1_opcode;
  else_e             s1_else_sel;
  flags_t            s1_flags_in;
  logic [half_w-1:0] s1_lo, s1_a_hi, s1_b_hi;

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid) begin
      s1_cond_ok  <= cond_ok;
      s1_carry    <= lo_sum[half_w];
      s1_tag      <= in_op.tag;
      s1_opcode   <= in_op.opcode;
      s1_else_sel <= in_op.else_sel;
      s1_flags_in <= in_op.flags_in;
      s1_lo       <= lo_val;
      s1_a_hi     <= in_op.a[xlen-1:half_w];
      s1_b_hi     <= in_op.b[xlen-1:half_w];
    end
  end

  logic [half_w-1:0] b_hi_eff, hi_val;
  logic [half_w:0]   hi_sum;
  logic              is_arith;
  logic [xlen-1:0]   value;
  flags_t            flags;

  // stage 2: high half and flags
  always_comb begin
    b_hi_eff = (s1_opcode == op_sub) ? ~s1_b_hi : s1_b_hi;
    hi_sum   = {1'b0, s1_a_hi} + {1'b0, b_hi_eff} + {{half_w{1'b0}}, s1_carry};
    is_arith = (s1_opcode == op_add) || (s1_opcode == op_sub);
    case (s1_opcode)
      op_add, op_sub: hi_val = hi_sum[half_w-1:0];
      op_and:         hi_val = s1_a_hi & s1_b_hi;
      op_or:          hi_val = s1_a_hi | s1_b_hi;
      op_xor:         hi_val = s1_a_hi ^ s1_b_hi;
      default:        hi_val = {half_w{s1_lo[half_w-1]}}; // sign fill from low half
    endcase
    if (!s1_cond_ok) begin
      case (s1_else_sel)
        else_a:  hi_val = s1_a_hi;
        else_ones: hi_val = '1;
        default: hi_val = '0; // one and zero
      endcase
    end
    value   = {hi_val, s1_lo};
    flags.n = value[xlen-1];
    flags.z = ~|value;
    flags.c = is_arith && hi_sum[half_w];
    // same operand signs, different result sign
    flags.v = is_arith && (s1_a_hi[half_w-1] == b_hi_eff[half_w-1])
              && (hi_sum[half_w-1] != s1_a_hi[half_w-1]);
    if (!s1_cond_ok) begin
      flags = s1_flags_in;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (s1_valid) begin
      out_res.tag   <= s1_tag;
      out_res.value <= value;
      out_res.flags <= flags;
    end
  end

endmodule

`default_nettype wire

// ==== design/exec_cfg_pkg.sv ====
// cluster sizing; num_lanes must be a power of two, the pipeline halves assume xlen = 2 * half_w
`default_nettype none

package exec_cfg_pkg;

  // datapath
  localparam int xlen   = 64;
  localparam int half_w = xlen / 2; // one pipeline half

  // lane array
  localparam int num_lanes = 4;
  localparam int lane_w    = $clog2(num_lanes);

  // operation tag travels untouched from issue to result
  localparam int tag_w = 8;

endpackage

`default_nettype wire

// ==== design/exec_cluster.sv ====
// fixed 3-cycle latency from issue to result, results in issue order, no back-pressure
`default_nettype none

module exec_cluster (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      issue_valid,
  input  exec_types_pkg::exec_op_t  issue_op,
  output logic                      res_valid,
  output exec_types_pkg::exec_res_t res
);
  import exec_cfg_pkg::*;
  import exec_types_pkg::*;

  logic [num_lanes-1:0] lane_valid;
  exec_op_t             lane_op;
  logic [num_lanes-1:0] out_valid;
  lane_res_t            out_res [num_lanes];

  issue_dispatch i_dispatch (
    .clk         (clk),
    .rst         (rst),
    .issue_valid (issue_valid),
    .issue_op    (issue_op),
    .lane_valid  (lane_valid),
    .lane_op     (lane_op)
  );

  for (genvar i = 0; i < num_lanes; i++) begin : g_lane
    alu_lane i_lane (
      .clk       (clk),
      .rst       (rst),
      .in_valid  (lane_valid[i]),
      .in_op     (lane_op),
      .out_valid (out_valid[i]),
      .out_res   (out_res[i])
    );
  end

  result_collect i_collect (
    .clk           (clk),
    .rst           (rst),
    .lane_valid_in (out_valid),
    .lane_res_in   (out_res),
    .res_valid     (res_valid),
    .res           (res)
  );

endmodule

`default_nettype wire

// ==== design/exec_types_pkg.sv ====
// operation and result formats; condition codes follow the ARM encoding, cond_nv never passes
`default_nettype none

package exec_types_pkg;
  import exec_cfg_pkg::*;

  typedef enum logic [2:0] {
    op_add,
    op_sub,
    op_and,
    op_or,
    op_xor,
    op_sxtb,
    op_sxth,
    op_sxtw
  } op_e;

  typedef enum logic [3:0] {
    cond_eq, cond_ne, cond_cs, cond_cc,
    cond_mi, cond_pl, cond_vs, cond_vc,
    cond_hi, cond_ls, cond_ge, cond_lt,
    cond_gt, cond_le, cond_al, cond_nv
  } cond_e;

  // value delivered when the condition fails
  typedef enum logic [1:0] {
    else_a,
    else_one,
    else_zero,
    else_ones
  } else_e;

  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } flags_t;

  typedef struct packed {
    logic [tag_w-1:0] tag;
    op_e              opcode;
    cond_e            cond;
    else_e            else_sel;
    logic [xlen-1:0]  a;
    logic [xlen-1:0]  b;
    flags_t           flags_in; // tested by cond, passed through on a miss
  } exec_op_t;

  typedef struct packed {
    logic [tag_w-1:0] tag;
    logic [xlen-1:0]  value;
    flags_t           flags;
  } lane_res_t;

  typedef struct packed {
    logic [tag_w-1:0]  tag;
    logic [xlen-1:0]   value;
    flags_t            flags;
    logic [lane_w-1:0] lane; // lane that produced it
  } exec_res_t;

endpackage

`default_nettype wire

// ==== design/issue_dispatch.sv ====
// one operation per clock, no stall input; lanes are assumed free again after num_lanes cycles
`default_nettype none

module issue_dispatch (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                issue_valid,
  input  exec_types_pkg::exec_op_t            issue_op,
  output logic [exec_cfg_pkg::num_lanes-1:0]  lane_valid,
  output exec_types_pkg::exec_op_t            lane_op
);
  import exec_cfg_pkg::*;

  logic [lane_w-1:0] ptr; // next lane to receive work

  // strobe and round-robin pointer
  always_ff @(posedge clk) begin
    if (rst) begin
      lane_valid <= '0;
      ptr        <= '0;
    end else begin
      lane_valid <= '0;
      if (issue_valid) begin
        lane_valid[ptr] <= 1'b1;
        if (ptr == lane_w'(num_lanes - 1)) begin
          ptr <= '0;
        end else begin
          ptr <= ptr + 1'b1;
        end
      end
    end
  end

  // operation shared by all lanes, only the strobed one takes it
  always_ff @(posedge clk) begin
    if (issue_valid) begin
      lane_op <= issue_op;
    end
  end

endmodule

`default_nettype wire

// ==== design/result_collect.sv ====
// expects at most one lane valid per cycle; with several the highest lane wins
`default_nettype none

module result_collect (
  input  logic                                clk,
  input  logic                                rst,
  input  logic [exec_cfg_pkg::num_lanes-1:0]  lane_valid_in,
  input  exec_types_pkg::lane_res_t           lane_res_in [exec_cfg_pkg::num_lanes],
  output logic                                res_valid,
  output exec_types_pkg::exec_res_t           res
);
  import exec_cfg_pkg::*;

  logic [lane_w-1:0] sel; // encoded valid lane

  always_comb begin
    sel = '0;
    for (int i = 0; i < num_lanes; i++) begin
      if (lane_valid_in[i]) begin
        sel = lane_w'(i);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      res_valid <= 1'b0;
    end else begin
      res_valid <= |lane_valid_in; // one-cycle pulse per result
    end
  end

  always_ff @(posedge clk) begin
    if (|lane_valid_in) begin
      res.tag   <= lane_res_in[sel].tag;
      res.value <= lane_res_in[sel].value;
      res.flags <= lane_res_in[sel].flags;
      res.lane  <= sel;
    end
  end

endmodule

`default_nettype wire

// ==== sources.f ====
design/exec_cfg_pkg.sv
design/exec_types_pkg.sv
design/issue_dispatch.sv
design/alu_lane.sv
design/result_collect.sv
design/exec_cluster.sv
tb/tb_clock_gen.sv
tb/exec_cluster_sva.sv
tb/tb_exec_cluster.sv

// ==== tb/exec_cluster_sva.sv ====
// edge-sampled checks, so a 3-cycle latency shows as 4 edges; issue_valid assumed low in reset
`default_nettype none

module exec_cluster_sva (
  input logic                               clk,
  input logic                               rst,
  input logic                               issue_valid,
  input logic                               res_valid,
  input logic [exec_cfg_pkg::num_lanes-1:0] lane_valid
);
  timeunit 1ns;
  timeprecision 1ps;

  a_reset_quiet: assert property (@(posedge clk) rst |=> !res_valid)
    else $error("res_valid high right after a reset edge");

  // issue seen at edge N, result seen at edge N+4
  a_latency: assert property (@(posedge clk) disable iff (rst) issue_valid |-> ##4 res_valid)
    else $error("no result 3 cycles after an issue");

  a_no_stray: assert property (@(posedge clk) disable iff (rst)
                               res_valid |-> $past(issue_valid, 4))
    else $error("result without an issue 3 cycles before");

  a_one_lane: assert property (@(posedge clk) disable iff (rst) $onehot0(lane_valid))
    else $error("more than one lane strobed in one cycle");

endmodule

bind exec_cluster exec_cluster_sva i_sva (
  .clk         (clk),
  .rst         (rst),
  .issue_valid (issue_valid),
  .res_valid   (res_valid),
  .lane_valid  (lane_valid)
);

`default_nettype wire

// ==== tb/tb_clock_gen.sv ====
// 8 ns clock from time zero; rst is released 1 ns after the second rising edge
`default_nettype none

module tb_clock_gen (
  output logic clk,
  output logic rst
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // two reset edges
  initial begin
    rst = 1'b1;
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;
  end

endmodule

`default_nettype wire

// ==== tb/tb_exec_cluster.sv ====
// expected results come from the op rules; lane numbers assume round-robin from lane 0 at reset
`default_nettype none

module tb_exec_cluster;
  timeunit 1ns;
  timeprecision 1ps;
  import exec_cfg_pkg::*;
  import exec_types_pkg::*;

  localparam int num_ops = 1 + 22 + 24 + 64 + 48;
  localparam int wd_ns   = num_ops * 8 + 1500; // margin for gaps, drains and reset

  typedef struct packed {
    exec_res_t   res;
    logic [31:0] issue_cyc;
  } exp_t;

  logic      clk, rst, issue_valid, res_valid;
  exec_op_t  issue_op;
  exec_res_t res;

  exp_t              exp_q[$];
  logic [15:0]       lfsr = 16'd54669;
  int                cycle = 0;
  int                errors = 0;
  int                err_base = 0;
  int                checks = 0;
  int                tests = 0;
  logic [lane_w-1:0] rr_lane = '0;
  logic [tag_w-1:0]  next_tag = '0;
  string             test_name = "none";

  tb_clock_gen i_clk (.clk(clk), .rst(rst));

  exec_cluster i_dut (
    .clk         (clk),
    .rst         (rst),
    .issue_valid (issue_valid),
    .issue_op    (issue_op),
    .res_valid   (res_valid),
    .res         (res)
  );

  // galois lfsr, one step per bit taken
  function automatic logic [63:0] rand_bits(int n);
    logic [63:0] r;
    logic        b;
    r = '0;
    for (int i = 0; i < n; i++) begin
      b    = lfsr[0];
      lfsr = lfsr >> 1;
      if (b) lfsr = lfsr ^ 16'hb400;
      r    = {r[62:0], b};
    end
    return r;
  endfunction

  // arm encoding: pairs share a test, odd code inverts it
  function automatic logic cond_pass(logic [3:0] cond, flags_t f);
    logic base;
    case (cond[3:1])
      3'd0:    base = f.z;
      3'd1:    base = f.c;
      3'd2:    base = f.n;
      3'd3:    base = f.v;
      3'd4:    base = f.c & ~f.z;
      3'd5:    base = (f.n == f.v);
      3'd6:    base = ~f.z & (f.n == f.v);
      default: base = 1'b1; // al, nv inverted
    endcase
    return base ^ cond[0];
  endfunction

  function automatic lane_res_t model_result(exec_op_t op);
    lane_res_t   r;
    logic [64:0] sum;
    r.tag   = op.tag;
    r.flags = '0;
    sum     = '0;
    case (op.opcode)
      op_add: begin
        sum       = {1'b0, op.a} + {1'b0, op.b};
        r.flags.v = (op.a[63] == op.b[63]) && (sum[63] != op.a[63]);
      end
      op_sub: begin
        sum       = {1'b0, op.a} + {1'b0, ~op.b} + 65'd1; // carry set means no borrow
        r.flags.v = (op.a[63] != op.b[63]) && (sum[63] != op.a[63]);
      end
      op_and:  sum[63:0] = op.a & op.b;
      op_or:   sum[63:0] = op.a | op.b;
      op_xor:  sum[63:0] = op.a ^ op.b;
      op_sxtb: sum[63:0] = {{56{op.a[7]}}, op.a[7:0]};
      op_sxth: sum[63:0] = {{48{op.a[15]}}, op.a[15:0]};
      default: sum[63:0] = {{32{op.a[31]}}, op.a[31:0]};
    endcase
    r.value   = sum[63:0];
    r.flags.n = sum[63];
    r.flags.z = (sum[63:0] == 64'd0);
    r.flags.c = sum[64];
    if (!cond_pass(op.cond, op.flags_in)) begin
      r.flags = op.flags_in;
      case (op.else_sel)
        else_a:    r.value = op.a;
        else_one:  r.value = 64'd1;
        else_zero: r.value = '0;
        default:   r.value = '1;
      endcase
    end
    return r;
  endfunction

  function automatic exec_op_t rand_op(op_e opc, cond_e cond);
    exec_op_t op;
    op.tag      = next_tag;
    next_tag    = next_tag + 1'b1;
    op.opcode   = opc;
    op.cond     = cond;
    op.else_sel = else_e'(2'(rand_bits(2)));
    op.a        = rand_bits(64);
    op.b        = rand_bits(64);
    op.flags_in = 4'(rand_bits(4));
    return op;
  endfunction

  // called at posedge + 1 ns, returns one cycle later
  task automatic issue(exec_op_t op);
    exp_t e;
    e.res       = {model_result(op), rr_lane};
    e.issue_cyc = cycle + 1; // taken at the next edge
    exp_q.push_back(e);
    rr_lane     = (rr_lane == lane_w'(num_lanes - 1)) ? '0 : rr_lane + 1'b1;
    issue_valid = 1'b1;
    issue_op    = op;
    @(posedge clk);
    #1;
    issue_valid = 1'b0;
  endtask

  task automatic directed(op_e opc, logic [63:0] a, logic [63:0] b);
    exec_op_t op;
    op   = rand_op(opc, cond_al);
    op.a = a;
    op.b = b;
    issue(op);
  endtask

  task automatic report_mismatch(string what, logic [63:0] exp_v, logic [63:0] act_v);
    $display("[ERROR] %s %s: expected %h actual %h", test_name, what, exp_v, act_v);
    errors++;
  endtask

  task automatic start_test(string name);
    test_name = name;
    err_base  = errors;
  endtask

  task automatic finish_test();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < 8) begin // latency is 3
      @(posedge clk);
      waited++;
    end
    repeat (2) @(posedge clk); // catch stray results
    #1;
    if (exp_q.size() != 0) begin
      $display("%0d results never arrived in %s", exp_q.size(), test_name);
      errors++;
      exp_q.delete();
    end
    tests++;
    $display("%s done, %0d errors", test_name, errors - err_base);
  endtask

  always @(posedge clk) cycle <= cycle + 1;

  // compare away from the edge
  always @(negedge clk) begin
    exp_t e;
    if (!rst && res_valid) begin
      if (exp_q.size() == 0) begin
        $display("result with tag %h arrived with nothing outstanding in %s", res.tag, test_name);
        errors++;
      end else begin
        e = exp_q.pop_front();
        checks++;
        if (res.tag !== e.res.tag) report_mismatch("tag", e.res.tag, res.tag);
        if (res.value !== e.res.value) report_mismatch("value", e.res.value, res.value);
        if (res.flags !== e.res.flags) report_mismatch("flags", e.res.flags, res.flags);
        if (res.lane !== e.res.lane) report_mismatch("lane", e.res.lane, res.lane);
        if (cycle - e.issue_cyc != 3) begin
          $display("result with tag %h came %0d cycles after issue in %s instead of 3",
                   res.tag, cycle - e.issue_cyc, test_name);
          errors++;
        end
      end
    end
  end

  initial begin
    #(wd_ns);
    $display("watchdog expired with %0d results outstanding in %s", exp_q.size(), test_name);
    $display("FAIL: see errors above");
    $finish;
  end

  initial begin
    exec_op_t op;
    issue_valid = 1'b0;
    issue_op    = '0;

    start_test("reset");
    wait (rst === 1'b0);
    repeat (4) begin
      @(negedge clk);
      if (res_valid !== 1'b0) report_mismatch("idle res_valid", 64'd0, res_valid);
    end
    @(posedge clk);
    #1;
    issue(rand_op(op_add, cond_al));
    finish_test();

    start_test("add_sub");
    directed(op_add, 64'h0000_0000_ffff_ffff, 64'd1); // carry across bit 31
    directed(op_add, '1, 64'd1);
    directed(op_add, 64'h7fff_ffff_ffff_ffff, 64'd1); // signed overflow
    directed(op_sub, 64'd0, 64'd1);
    directed(op_sub, 64'h8000_0000_0000_0000, 64'd1);
    directed(op_sub, 64'd5, 64'd5);
    repeat (16) issue(rand_op(rand_bits(1) ? op_sub : op_add, cond_al));
    finish_test();

    start_test("logic_sxt");
    repeat (24) issue(rand_op(op_e'(3'(2 + rand_bits(3) % 6)), cond_al));
    finish_test();

    start_test("conditions");
    for (int ci = 0; ci < 16; ci++) begin
      for (int ei = 0; ei < 4; ei++) begin
        op          = rand_op(op_e'(3'(rand_bits(3))), cond_e'(4'(ci)));
        op.else_sel = else_e'(2'(ei));
        issue(op);
      end
    end
    finish_test();

    start_test("back_to_back");
    for (int i = 0; i < 48; i++) begin
      if (rand_bits(2) == 0) begin
        @(posedge clk); // idle gap
        #1;
      end
      issue(rand_op(op_e'(3'(rand_bits(3))), cond_e'(4'(rand_bits(4)))));
    end
    finish_test();

    $display("%0d tests, %0d results checked, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire
